// ==== project.f ====
+incdir+rtl
rtl/fifo_pkg.sv
rtl/dual_port_ram.sv
rtl/ptr_sync.sv
rtl/wr_ptr_ctrl.sv
rtl/rd_ptr_ctrl.sv
rtl/async_fifo.sv
verification/async_fifo_properties.sv
verification/async_fifo_tb.sv

// ==== rtl/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
  input  logic           wr_clk,
  input  logic           wr_rst_n,
  input  logic           wr_en,
  input  fifo_pkg::data_t wr_data,
  input  logic           rd_clk,
  input  logic           rd_rst_n,
  input  logic           rd_en,
  output fifo_pkg::data_t rd_data,
  output logic           full,
  output logic           empty,
  output logic           afull,
  output logic           aempty
);

  logic           we;
  logic           re;
  fifo_pkg::addr_t waddr;
  fifo_pkg::addr_t raddr;
  fifo_pkg::ptr_t  wr_gray;
  fifo_pkg::ptr_t  rd_gray;
  fifo_pkg::ptr_t  wr_gray_sync;  // on rd_clk
  fifo_pkg::ptr_t  rd_gray_sync;  // on wr_clk

  wr_ptr_ctrl u_wr_ptr_ctrl (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_gray_sync (rd_gray_sync),
    .we           (we),
    .waddr        (waddr),
    .wr_gray      (wr_gray),
    .full         (full),
    .afull        (afull)
  );

  rd_ptr_ctrl u_rd_ptr_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_gray_sync (wr_gray_sync),
    .re           (re),
    .raddr        (raddr),
    .rd_gray      (rd_gray),
    .empty        (empty),
    .aempty       (aempty)
  );

  dual_port_ram u_ram (
    .wr_clk   (wr_clk),
    .we       (we),
    .waddr    (waddr),
    .wdata    (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .re       (re),
    .raddr    (raddr),
    .rd_data  (rd_data)
  );

  // write pointer into the read domain
  ptr_sync rd_side_sync (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_sync)
  );

  // read pointer into the write domain
  ptr_sync wr_side_sync (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_sync)
  );

endmodule

// ==== rtl/dual_port_ram.sv ====
`timescale 1ns/1ps

`include "fifo_defines.svh"

module dual_port_ram (
  input  logic           wr_clk,
  input  logic           we,
  input  fifo_pkg::addr_t waddr,
  input  fifo_pkg::data_t wdata,
  input  logic           rd_clk,
  input  logic           rd_rst_n,
  input  logic           re,
  input  fifo_pkg::addr_t raddr,
  output fifo_pkg::data_t rd_data
);

  fifo_pkg::data_t mem [0:`FIFO_DEPTH-1];

  // write port, wr_clk domain
  always_ff @(posedge wr_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read port, holds the last word between reads
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (re) begin
      rd_data <= mem[raddr];
    end
  end

endmodule

// ==== rtl/fifo_defines.svh ====
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// word width carried through the fifo
`define FIFO_DATA_WIDTH 8

// storage size, power of two only
`define FIFO_DEPTH 16

// ram address bits, pointers carry one extra wrap bit
`define FIFO_ADDR_WIDTH 4

// afull once used count reaches this
`define FIFO_AFULL 14

// aempty while used count is at or below this
`define FIFO_AEMPTY 1

`endif

// ==== rtl/fifo_pkg.sv ====
`include "fifo_defines.svh"

package fifo_pkg;

  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`FIFO_ADDR_WIDTH:0]   ptr_t;  // binary or gray, msb is wrap

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // msb passes through, each lower bit folds in the bits above it
  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[`FIFO_ADDR_WIDTH] = gray[`FIFO_ADDR_WIDTH];
    for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== rtl/ptr_sync.sv ====
`timescale 1ns/1ps

// brings a gray pointer into the clk domain
// only one bit moves per pointer step, so a sample taken mid-change
// resolves to either the old or the new value, never a mix
module ptr_sync (
  input  logic          clk,
  input  logic          rst_n,
  input  fifo_pkg::ptr_t gray_in,
  output fifo_pkg::ptr_t gray_out
);

  fifo_pkg::ptr_t meta_q;  // first stage, may go metastable
  fifo_pkg::ptr_t sync_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= gray_in;
      sync_q <= meta_q;
    end
  end

  assign gray_out = sync_q;

endmodule

// ==== rtl/rd_ptr_ctrl.sv ====
`timescale 1ns/1ps

`include "fifo_defines.svh"

module rd_ptr_ctrl (
  input  logic           rd_clk,
  input  logic           rd_rst_n,
  input  logic           rd_en,
  input  fifo_pkg::ptr_t  wr_gray_sync,
  output logic           re,
  output fifo_pkg::addr_t raddr,
  output fifo_pkg::ptr_t  rd_gray,
  output logic           empty,
  output logic           aempty
);

  localparam int AW = `FIFO_ADDR_WIDTH;

  fifo_pkg::ptr_t rd_bin;
  fifo_pkg::ptr_t rd_bin_nxt;
  fifo_pkg::ptr_t rd_gray_nxt;
  fifo_pkg::ptr_t wr_bin_sync;
  fifo_pkg::ptr_t used_nxt;
  logic          rd_ok;
  logic          empty_nxt;
  logic          aempty_nxt;

  // a read while empty is ignored, nothing popped
  assign rd_ok = rd_en & ~empty;

  assign rd_bin_nxt  = rd_bin + fifo_pkg::ptr_t'(rd_ok);
  assign rd_gray_nxt = fifo_pkg::bin2gray(rd_bin_nxt);

  // write pointer as seen from rd_clk
  assign wr_bin_sync = fifo_pkg::gray2bin(wr_gray_sync);
  assign used_nxt    = wr_bin_sync - rd_bin_nxt;

  // pointers equal including wrap bit
  assign empty_nxt  = (rd_gray_nxt == wr_gray_sync);
  assign aempty_nxt = (used_nxt <= fifo_pkg::ptr_t'(`FIFO_AEMPTY));

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // empty goes high on the edge that takes the last word
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

  assign re    = rd_ok;
  assign raddr = rd_bin[AW-1:0];

endmodule

// ==== rtl/wr_ptr_ctrl.sv ====
`timescale 1ns/1ps

`include "fifo_defines.svh"

module wr_ptr_ctrl (
  input  logic           wr_clk,
  input  logic           wr_rst_n,
  input  logic           wr_en,
  input  fifo_pkg::ptr_t  rd_gray_sync,
  output logic           we,
  output fifo_pkg::addr_t waddr,
  output fifo_pkg::ptr_t  wr_gray,
  output logic           full,
  output logic           afull
);

  localparam int AW = `FIFO_ADDR_WIDTH;

  fifo_pkg::ptr_t wr_bin;
  fifo_pkg::ptr_t wr_bin_nxt;
  fifo_pkg::ptr_t wr_gray_nxt;
  fifo_pkg::ptr_t rd_bin_sync;
  fifo_pkg::ptr_t full_match;  // gray read pointer one lap behind
  fifo_pkg::ptr_t used_nxt;
  logic          wr_ok;
  logic          full_nxt;
  logic          afull_nxt;

  // back-pressure, a write while full is dropped
  assign wr_ok = wr_en & ~full;

  assign wr_bin_nxt  = wr_bin + fifo_pkg::ptr_t'(wr_ok);
  assign wr_gray_nxt = fifo_pkg::bin2gray(wr_bin_nxt);

  // read side view, 2 to 3 wr_clk edges old
  assign rd_bin_sync = fifo_pkg::gray2bin(rd_gray_sync);
  assign used_nxt    = wr_bin_nxt - rd_bin_sync;

  // full when the two top gray bits differ and the rest agree
  assign full_match = {~rd_gray_sync[AW:AW-1], rd_gray_sync[AW-2:0]};
  assign full_nxt   = (wr_gray_nxt == full_match);
  assign afull_nxt  = (used_nxt >= fifo_pkg::ptr_t'(`FIFO_AFULL));

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;  // registered so the sync sees a clean gray code
    end
  end

  // flags include a write on the same edge
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

  assign we    = wr_ok;
  assign waddr = wr_bin[AW-1:0];  // drop wrap bit for the ram

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the async FIFO testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert \
  -f project.f \
  --top-module async_fifo_tb \
  -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "run_sim: compile failed"
  exit 1
fi

"./$OBJ/Vasync_fifo_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "run_sim: simulation exited with status $status"
  exit 1
fi

if grep -q "^No errors$" "$LOG"; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi

// ==== verification/async_fifo_properties.sv ====
`timescale 1ns/1ps

`include "fifo_defines.svh"

module async_fifo_properties (
  input logic           wr_clk,
  input logic           wr_rst_n,
  input logic           rd_clk,
  input logic           rd_rst_n,
  input logic           we,
  input logic           re,
  input logic           full,
  input logic           afull,
  input logic           empty,
  input fifo_pkg::ptr_t wr_gray,
  input fifo_pkg::ptr_t rd_gray,
  input fifo_pkg::ptr_t wr_gray_sync,
  input fifo_pkg::ptr_t rd_gray_sync
);

  localparam int AW = `FIFO_ADDR_WIDTH;

  // gray pointers step one bit at a time
  wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1)
    else $error("wr_gray changed in more than one bit");

  rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1)
    else $error("rd_gray changed in more than one bit");

  // write pointer never a full lap ahead when a write lands
  no_write_when_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    we |-> wr_gray != {~rd_gray_sync[AW:AW-1], rd_gray_sync[AW-2:0]})
    else $error("write accepted while full");

  no_read_when_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    re |-> rd_gray != wr_gray_sync)
    else $error("read accepted while empty");

  // first cycle out of reset
  wr_reset_flags: assert property (@(posedge wr_clk) $rose(wr_rst_n) |-> !full && !afull)
    else $error("full or afull set after reset");

  rd_reset_flags: assert property (@(posedge rd_clk) $rose(rd_rst_n) |-> empty)
    else $error("empty low after reset");

endmodule

// ==== verification/async_fifo_tb.sv ====
`timescale 1ns/1ps

`include "fifo_defines.svh"

module async_fifo_tb;

  typedef struct packed {
    int n_wr;
    int n_rd;
    bit conc;       // writes and reads together
    int exp_full;   // -1 means not checked
    int exp_empty;
  } row_t;

  localparam int NUM_ROWS = 12;

  // trailing comments give the model count after each row
  row_t rows [NUM_ROWS] = '{
    '{10,  10,  1'b0, 0,  1},  // 0 after order and data
    '{20,  0,   1'b0, 1,  0},  // 16 after overfill
    '{0,   16,  1'b0, 0,  1},  // 0
    '{0,   4,   1'b0, 0,  1},  // 0 after reads on empty
    '{1,   0,   1'b0, 0,  0},  // 1
    '{1,   0,   1'b0, 0,  0},  // 2
    '{11,  0,   1'b0, 0,  0},  // 13
    '{1,   0,   1'b0, 0,  0},  // 14
    '{2,   0,   1'b0, 1,  0},  // 16
    '{0,   16,  1'b0, 0,  1},
    '{100, 100, 1'b1, -1, -1}, // random traffic across the wrap
    '{0,   20,  1'b0, 0,  1}   // drain
  };

  logic            wr_clk;
  logic            rd_clk;
  logic            wr_rst_n;
  logic            rd_rst_n;
  logic            wr_en;
  logic            rd_en;
  fifo_pkg::data_t wr_data;
  fifo_pkg::data_t rd_data;
  logic            full;
  logic            empty;
  logic            afull;
  logic            aempty;

  integer          seed = 32'h289e_9115;
  fifo_pkg::data_t model_q [$];
  fifo_pkg::data_t last_read;  // last word popped from the model
  int              cycle_count = 0;
  int              cycle_limit = 0;

  async_fifo DUT (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  bind async_fifo async_fifo_properties u_props (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .we           (we),
    .re           (re),
    .full         (full),
    .afull        (afull),
    .empty        (empty),
    .wr_gray      (wr_gray),
    .rd_gray      (rd_gray),
    .wr_gray_sync (wr_gray_sync),
    .rd_gray_sync (rd_gray_sync)
  );

  always #20 wr_clk = ~wr_clk;
  always #28 rd_clk = ~rd_clk;  // unrelated to wr_clk

  always @(posedge wr_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: run still going after %0d wr_clk cycles", cycle_count);
      $display("Errors found");
      $fatal(1, "stopped on timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_almost_flags();
    check_value("afull", afull, model_q.size() >= `FIFO_AFULL);
    check_value("aempty", aempty, model_q.size() <= `FIFO_AEMPTY);
  endtask

  // one extra pass drops wr_en and checks the last write
  task automatic write_phase(input int n, input bit rand_en);
    logic [31:0] r;
    logic        en;
    for (int i = 0; i <= n; i++) begin
      @(posedge wr_clk);
      #2;
      if (!rand_en) begin
        check_value("full", full, model_q.size() >= `FIFO_DEPTH);
        check_value("afull", afull, model_q.size() >= `FIFO_AFULL);
      end
      en = 1'b0;
      if (i < n) begin
        r = $random(seed);
        en = rand_en ? r[0] : 1'b1;
        r = $random(seed);
        wr_data = r[`FIFO_DATA_WIDTH-1:0];
      end
      wr_en = en;
      if (en && !full) begin
        model_q.push_back(wr_data);
      end
    end
  endtask

  task automatic read_phase(input int n, input bit rand_en);
    logic [31:0]     r;
    logic            en;
    logic            pending;
    logic            hold;
    fifo_pkg::data_t exp_word;
    pending   = 1'b0;
    hold      = 1'b0;
    exp_word  = '0;
    for (int i = 0; i <= n; i++) begin
      @(posedge rd_clk);
      #2;
      if (pending) begin
        check_value("rd_data", rd_data, exp_word);
      end
      if (hold) begin
        check_value("rd_data", rd_data, last_read);  // ignored read keeps old word
      end
      pending = 1'b0;
      hold    = 1'b0;
      if (!rand_en) begin
        check_value("empty", empty, model_q.size() == 0);
        check_value("aempty", aempty, model_q.size() <= `FIFO_AEMPTY);
      end
      en = 1'b0;
      if (i < n) begin
        r  = $random(seed);
        en = rand_en ? r[0] : 1'b1;
      end
      rd_en = en;
      if (en && !empty) begin
        exp_word  = model_q.pop_front();
        last_read = exp_word;
        pending   = 1'b1;
      end else if (en) begin
        hold = 1'b1;
      end
    end
  endtask

  // lets both synchronizers catch up
  task automatic wait_settle();
    repeat (6) @(posedge rd_clk);
    #2;
  endtask

  task automatic check_row(input int idx);
    if (rows[idx].exp_full >= 0) begin
      check_value("full", full, rows[idx].exp_full);
    end
    if (rows[idx].exp_empty >= 0) begin
      check_value("empty", empty, rows[idx].exp_empty);
    end
    if (rows[idx].exp_empty == 1) begin
      check_value("model_count", model_q.size(), 0);  // nothing lost or doubled
    end
    check_almost_flags();
  endtask

  initial begin
    int total;
    wr_clk    = 1'b0;
    rd_clk    = 1'b0;
    wr_rst_n  = 1'b0;
    rd_rst_n  = 1'b0;
    wr_en     = 1'b0;
    rd_en     = 1'b0;
    wr_data   = '0;
    last_read = '0;
    total     = 0;
    foreach (rows[i]) begin
      total += rows[i].n_wr + rows[i].n_rd;
    end
    cycle_limit = 4 * total + 200;

    repeat (3) @(posedge wr_clk);
    #2;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;

    check_value("empty", empty, 1);
    check_value("aempty", aempty, 1);
    check_value("full", full, 0);
    check_value("afull", afull, 0);
    check_value("rd_data", rd_data, 0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].conc) begin
        fork
          write_phase(rows[i].n_wr, 1'b1);
          read_phase(rows[i].n_rd, 1'b1);
        join
      end else begin
        if (rows[i].n_wr > 0) begin
          write_phase(rows[i].n_wr, 1'b0);
          wait_settle();
        end
        if (rows[i].n_rd > 0) begin
          read_phase(rows[i].n_rd, 1'b0);
        end
      end
      wait_settle();
      check_row(i);
    end

    $display("No errors");
    $finish;
  end

endmodule
